/* source/exec_types_pkg.sv */
// Data width types shared by the execute stage blocks
package exec_types_pkg;

    // Operand and result value
    typedef logic [31:0] word_t;

    // Destination register address
    typedef logic [4:0] reg_addr_t;

    // Program counter bits 31 down to 1, bit 0 is always zero
    typedef logic [31:1] pc_t;

    // Comparison flags from register read, {lt, ltu, eq}
    typedef logic [2:0] cmp_flags_t;

    // Flag positions inside cmp_flags_t
    localparam int FLAG_LT  = 2;
    localparam int FLAG_LTU = 1;
    localparam int FLAG_EQ  = 0;

endpackage

/* source/exec_ops_pkg.sv */
// Micro-op field encodings for the execute stage
package exec_ops_pkg;

    // Functional unit of the micro-op
    typedef enum logic [2:0] {
        UNIT_NONE      = 3'd0,
        UNIT_ALU       = 3'd1,
        UNIT_DIV       = 3'd2,
        UNIT_BRANCH    = 3'd3,
        UNIT_JUMP_LINK = 3'd4
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        DIV_DIV  = 2'd0,
        DIV_DIVU = 2'd1,
        DIV_REM  = 2'd2,
        DIV_REMU = 2'd3
    } div_op_e;

    // Branch condition, JAL and JALR are unconditional
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_LT   = 4'd3,
        BR_GE   = 4'd4,
        BR_LTU  = 4'd5,
        BR_GEU  = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } branch_e;

endpackage

/* source/exec_issue.sv */
// Execute issue side, unit selects, divider start pulse and branch decision
`timescale 1ns/1ns

module exec_issue (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  exec_ops_pkg::unit_e        unit_i,
    input  exec_ops_pkg::branch_e      branch_i,
    input  exec_types_pkg::cmp_flags_t cmp_flags_i,
    input  logic                       div_busy_i,
    input  logic                       div_done_i,
    output logic                       alu_sel_o,
    output logic                       div_sel_o,
    output logic                       link_sel_o,
    output logic                       div_start_o,
    output logic                       branch_taken_o
);

    logic started_q; // Held DIV op already launched

    assign alu_sel_o  = (unit_i == exec_ops_pkg::UNIT_ALU);
    assign div_sel_o  = (unit_i == exec_ops_pkg::UNIT_DIV);
    assign link_sel_o = (unit_i == exec_ops_pkg::UNIT_JUMP_LINK);

    // One start per DIV op, never in the done cycle
    assign div_start_o = div_sel_o & ~started_q & ~div_busy_i & ~div_done_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            started_q <= 1'b0;
        end else if (div_start_o) begin
            started_q <= 1'b1;
        end else if (div_done_i || !div_sel_o) begin
            started_q <= 1'b0; // Ready for the next op
        end
    end

    always_comb begin
        case (branch_i)
            exec_ops_pkg::BR_EQ:   branch_taken_o =  cmp_flags_i[exec_types_pkg::FLAG_EQ];
            exec_ops_pkg::BR_NE:   branch_taken_o = !cmp_flags_i[exec_types_pkg::FLAG_EQ];
            exec_ops_pkg::BR_LT:   branch_taken_o =  cmp_flags_i[exec_types_pkg::FLAG_LT];
            exec_ops_pkg::BR_GE:   branch_taken_o = !cmp_flags_i[exec_types_pkg::FLAG_LT];
            exec_ops_pkg::BR_LTU:  branch_taken_o =  cmp_flags_i[exec_types_pkg::FLAG_LTU];
            exec_ops_pkg::BR_GEU:  branch_taken_o = !cmp_flags_i[exec_types_pkg::FLAG_LTU];
            exec_ops_pkg::BR_JAL:  branch_taken_o = 1'b1;
            exec_ops_pkg::BR_JALR: branch_taken_o = 1'b1;
            // Read every cycle, so unknown codes must not jump
            default:               branch_taken_o = 1'b0;
        endcase
    end

endmodule

/* source/exec_alu.sv */
// Integer ALU, single cycle, its adder also gives branch and jump targets
`timescale 1ns/1ns

module exec_alu (
    input  exec_ops_pkg::alu_op_e  alu_op_i,
    input  exec_types_pkg::word_t  operand_a_i,
    input  exec_types_pkg::word_t  operand_b_i,
    output exec_types_pkg::word_t  result_o,
    output exec_types_pkg::pc_t    target_o
);

    exec_types_pkg::word_t sum;
    logic [4:0]            shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;

    assign sum         = operand_a_i + operand_b_i;
    assign shamt       = operand_b_i[4:0];
    assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
    assign lt_unsigned = operand_a_i < operand_b_i;

    // Target from the sum regardless of op, bit 0 dropped
    assign target_o = sum[31:1];

    always_comb begin
        case (alu_op_i)
            exec_ops_pkg::ALU_ADD: begin
                result_o = sum;
            end
            exec_ops_pkg::ALU_SUB: begin
                result_o = operand_a_i - operand_b_i;
            end
            exec_ops_pkg::ALU_AND: begin
                result_o = operand_a_i & operand_b_i;
            end
            exec_ops_pkg::ALU_OR: begin
                result_o = operand_a_i | operand_b_i;
            end
            exec_ops_pkg::ALU_XOR: begin
                result_o = operand_a_i ^ operand_b_i;
            end
            exec_ops_pkg::ALU_SLL: begin
                result_o = operand_a_i << shamt;
            end
            exec_ops_pkg::ALU_SRL: begin
                result_o = operand_a_i >> shamt;
            end
            exec_ops_pkg::ALU_SRA: begin
                result_o = $signed(operand_a_i) >>> shamt; // Sign fill
            end
            exec_ops_pkg::ALU_SLT: begin
                result_o = {31'b0, lt_signed};
            end
            exec_ops_pkg::ALU_SLTU: begin
                result_o = {31'b0, lt_unsigned};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* source/exec_divider.sv */
// Iterative restoring divider for DIV, DIVU, REM and REMU
`timescale 1ns/1ns

module exec_divider #(
    parameter int DIV_BITS_PER_CYCLE = 1
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  exec_ops_pkg::div_op_e  div_op_i,
    input  exec_types_pkg::word_t  dividend_i,
    input  exec_types_pkg::word_t  divisor_i,
    output exec_types_pkg::word_t  result_o,
    output logic                   busy_o,
    output logic                   done_o
);

    localparam int STEPS = 32 / DIV_BITS_PER_CYCLE;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } state_e;

    state_e                state_q;
    logic [5:0]            count_q;
    exec_types_pkg::word_t quo_q;      // Dividend shifts out, quotient shifts in
    exec_types_pkg::word_t rem_q;
    exec_types_pkg::word_t den_q;
    exec_types_pkg::word_t dividend_q; // Original value for divide by zero
    logic                  neg_quo_q;
    logic                  neg_rem_q;
    logic                  rem_op_q;
    logic                  zero_q;
    logic                  ovf_q;

    logic                  signed_op;
    logic                  rem_op;
    exec_types_pkg::word_t abs_a;
    exec_types_pkg::word_t abs_b;
    exec_types_pkg::word_t quo_n;
    exec_types_pkg::word_t rem_n;
    exec_types_pkg::word_t quo_fix;
    exec_types_pkg::word_t rem_fix;
    logic [32:0]           shifted;

    assign signed_op = (div_op_i == exec_ops_pkg::DIV_DIV) || (div_op_i == exec_ops_pkg::DIV_REM);
    assign rem_op    = (div_op_i == exec_ops_pkg::DIV_REM) || (div_op_i == exec_ops_pkg::DIV_REMU);
    assign abs_a     = (signed_op && dividend_i[31]) ? -dividend_i : dividend_i;
    assign abs_b     = (signed_op && divisor_i[31]) ? -divisor_i : divisor_i;

    // Shift-subtract steps retired this clock
    always_comb begin
        quo_n   = quo_q;
        rem_n   = rem_q;
        shifted = '0;
        for (int i = 0; i < DIV_BITS_PER_CYCLE; i++) begin
            shifted = {rem_n, quo_n[31]};
            if (shifted >= {1'b0, den_q}) begin
                rem_n = 32'(shifted - {1'b0, den_q});
                quo_n = {quo_n[30:0], 1'b1};
            end else begin
                rem_n = shifted[31:0]; // Restore
                quo_n = {quo_n[30:0], 1'b0};
            end
        end
    end

    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q; // Remainder follows dividend sign
    assign busy_o  = (state_q == RUN);
    assign done_o  = (state_q == FIX); // Final quotient and remainder in place

    // Sign fix and RISC-V special cases, held until the next start
    always_comb begin
        if (zero_q) begin
            result_o = rem_op_q ? dividend_q : '1;
        end else if (ovf_q) begin
            result_o = rem_op_q ? '0 : dividend_q; // Most negative over -1
        end else begin
            result_o = rem_op_q ? rem_fix : quo_fix;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        count_q <= '0;
                    end
                end
                RUN: begin
                    count_q <= count_q + 6'd1;
                    if (count_q == 6'(STEPS - 1)) begin
                        state_q <= FIX;
                    end
                end
                FIX: begin
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i && state_q == IDLE) begin
            quo_q      <= abs_a;
            rem_q      <= '0;
            den_q      <= abs_b;
            dividend_q <= dividend_i;
            neg_quo_q  <= signed_op && (dividend_i[31] ^ divisor_i[31]);
            neg_rem_q  <= signed_op && dividend_i[31];
            rem_op_q   <= rem_op;
            zero_q     <= (divisor_i == '0);
            ovf_q      <= signed_op && (dividend_i == 32'h8000_0000) &&
                          (divisor_i == 32'hffff_ffff);
        end else if (state_q == RUN) begin
            quo_q <= quo_n;
            rem_q <= rem_n;
        end
    end

endmodule

/* source/exec_writeback.sv */
// Execute output side, result select, forwarding value and writeback registers
`timescale 1ns/1ns

module exec_writeback (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      alu_sel_i,
    input  logic                      div_sel_i,
    input  logic                      link_sel_i,
    input  logic                      div_done_i,
    input  exec_types_pkg::reg_addr_t rd_addr_i,
    input  exec_types_pkg::pc_t       pc_next_i,
    input  exec_types_pkg::word_t     alu_result_i,
    input  exec_types_pkg::word_t     div_result_i,
    output exec_types_pkg::word_t     fwd_value_o,
    output logic                      forward_valid_o,
    output exec_types_pkg::reg_addr_t wb_rd_addr_o,
    output exec_types_pkg::word_t     wb_rd_value_o,
    output logic                      wb_write_o
);

    exec_types_pkg::word_t next_value;
    logic                  write_en;

    always_comb begin
        if (div_sel_i) begin
            next_value = div_result_i;
        end else if (link_sel_i) begin
            next_value = {pc_next_i, 1'b0}; // Link value PC+4
        end else begin
            next_value = alu_result_i;
        end
    end

    // DIV writes once, in the done cycle
    assign write_en = alu_sel_i | link_sel_i | (div_sel_i & div_done_i);

    assign fwd_value_o     = next_value;
    assign forward_valid_o = ~(div_sel_i & ~div_done_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_rd_addr_o  <= '0;
            wb_rd_value_o <= '0;
            wb_write_o    <= 1'b0;
        end else begin
            wb_rd_addr_o  <= rd_addr_i;
            wb_rd_value_o <= next_value;
            wb_write_o    <= write_en;
        end
    end

endmodule

/* source/exec_stage.sv */
// Execute stage top, joins issue, ALU, divider and writeback
`timescale 1ns/1ns

module exec_stage #(
    parameter int DIV_BITS_PER_CYCLE = 1
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  exec_ops_pkg::unit_e        unit_i,
    input  exec_ops_pkg::alu_op_e      alu_op_i,
    input  exec_ops_pkg::div_op_e      div_op_i,
    input  exec_ops_pkg::branch_e      branch_i,
    input  exec_types_pkg::reg_addr_t  rd_addr_i,
    input  exec_types_pkg::pc_t        pc_next_i,
    input  exec_types_pkg::word_t      operand_a_i,
    input  exec_types_pkg::word_t      operand_b_i,
    input  exec_types_pkg::cmp_flags_t cmp_flags_i,
    output logic                       branch_taken_o,
    output exec_types_pkg::pc_t        branch_target_o,
    output exec_types_pkg::word_t      fwd_value_o,
    output logic                       forward_valid_o,
    output exec_types_pkg::reg_addr_t  wb_rd_addr_o,
    output exec_types_pkg::word_t      wb_rd_value_o,
    output logic                       wb_write_o,
    output logic                       div_done_o
);

    logic                  alu_sel;
    logic                  div_sel;
    logic                  link_sel;
    logic                  div_start;
    logic                  div_busy;
    exec_types_pkg::word_t alu_result;
    exec_types_pkg::word_t div_result;

    exec_issue u_issue (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .unit_i         (unit_i),
        .branch_i       (branch_i),
        .cmp_flags_i    (cmp_flags_i),
        .div_busy_i     (div_busy),
        .div_done_i     (div_done_o),
        .alu_sel_o      (alu_sel),
        .div_sel_o      (div_sel),
        .link_sel_o     (link_sel),
        .div_start_o    (div_start),
        .branch_taken_o (branch_taken_o)
    );

    // Branch and jump targets come out of the ALU adder
    exec_alu u_alu (
        .alu_op_i    (alu_op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .result_o    (alu_result),
        .target_o    (branch_target_o)
    );

    exec_divider #(
        .DIV_BITS_PER_CYCLE (DIV_BITS_PER_CYCLE)
    ) u_divider (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .div_op_i   (div_op_i),
        .dividend_i (operand_a_i),
        .divisor_i  (operand_b_i),
        .result_o   (div_result),
        .busy_o     (div_busy),
        .done_o     (div_done_o)
    );

    exec_writeback u_writeback (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .alu_sel_i       (alu_sel),
        .div_sel_i       (div_sel),
        .link_sel_i      (link_sel),
        .div_done_i      (div_done_o),
        .rd_addr_i       (rd_addr_i),
        .pc_next_i       (pc_next_i),
        .alu_result_i    (alu_result),
        .div_result_i    (div_result),
        .fwd_value_o     (fwd_value_o),
        .forward_valid_o (forward_valid_o),
        .wb_rd_addr_o    (wb_rd_addr_o),
        .wb_rd_value_o   (wb_rd_value_o),
        .wb_write_o      (wb_write_o)
    );

endmodule

/* bench/exec_stage_tb.sv */
// Testbench for the execute stage, file driven vectors plus random ALU cases
`timescale 1ns/1ns

module exec_stage_tb;

    localparam int DIV_BITS   = 1;
    localparam int DONE_DELAY = 32 / DIV_BITS + 1; // Start cycle to done pulse
    localparam int MAX_VEC    = 32;
    localparam int WAIT_LIMIT = 100;

    logic                       clk_i;
    logic                       rst_i;
    exec_ops_pkg::unit_e        unit_i;
    exec_ops_pkg::alu_op_e      alu_op_i;
    exec_ops_pkg::div_op_e      div_op_i;
    exec_ops_pkg::branch_e      branch_i;
    exec_types_pkg::reg_addr_t  rd_addr_i;
    exec_types_pkg::pc_t        pc_next_i;
    exec_types_pkg::word_t      operand_a_i;
    exec_types_pkg::word_t      operand_b_i;
    exec_types_pkg::cmp_flags_t cmp_flags_i;
    logic                       branch_taken_o;
    exec_types_pkg::pc_t        branch_target_o;
    exec_types_pkg::word_t      fwd_value_o;
    logic                       forward_valid_o;
    exec_types_pkg::reg_addr_t  wb_rd_addr_o;
    exec_types_pkg::word_t      wb_rd_value_o;
    logic                       wb_write_o;
    logic                       div_done_o;

    // Vector fields, see the header of the data file
    logic [159:0] vectors [0:MAX_VEC-1];
    int           errors;
    int           tests;
    logic [31:0]  lcg_state;

    exec_stage #(
        .DIV_BITS_PER_CYCLE (DIV_BITS)
    ) u_dut (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .unit_i          (unit_i),
        .alu_op_i        (alu_op_i),
        .div_op_i        (div_op_i),
        .branch_i        (branch_i),
        .rd_addr_i       (rd_addr_i),
        .pc_next_i       (pc_next_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .cmp_flags_i     (cmp_flags_i),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .fwd_value_o     (fwd_value_o),
        .forward_valid_o (forward_valid_o),
        .wb_rd_addr_o    (wb_rd_addr_o),
        .wb_rd_value_o   (wb_rd_value_o),
        .wb_write_o      (wb_write_o),
        .div_done_o      (div_done_o)
    );

    always #2 clk_i = ~clk_i;

    task automatic check_word(input string name, input exec_types_pkg::word_t exp,
                              input exec_types_pkg::word_t act);
        if (exp !== act) begin
            $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input exec_types_pkg::reg_addr_t exp,
                              input exec_types_pkg::reg_addr_t act);
        if (exp !== act) begin
            $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, input exec_types_pkg::pc_t exp,
                            input exec_types_pkg::pc_t act);
        if (exp !== act) begin
            $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Reference ALU rules
    function automatic exec_types_pkg::word_t alu_expect(input logic [3:0] op,
                                                         input exec_types_pkg::word_t a,
                                                         input exec_types_pkg::word_t b);
        int sh;
        sh = int'(b[4:0]);
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return a << sh;
            4'd6:    return a >> sh;
            4'd7:    return exec_types_pkg::word_t'($signed(a) >>> sh);
            4'd8:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // Drive on the falling edge, check what the unit field calls for
    task automatic run_vector(input logic [159:0] v);
        exec_types_pkg::word_t sum;
        exec_types_pkg::word_t exp_val;
        int                    cycles;
        int                    errors_before;
        string                 kind;
        errors_before = errors;
        exp_val       = v[35:4];
        unit_i      = exec_ops_pkg::unit_e'(v[158:156]);
        alu_op_i    = exec_ops_pkg::alu_op_e'(v[155:152]);
        div_op_i    = exec_ops_pkg::div_op_e'(v[149:148]);
        branch_i    = exec_ops_pkg::branch_e'(v[147:144]);
        cmp_flags_i = v[142:140];
        operand_a_i = v[139:108];
        operand_b_i = v[107:76];
        rd_addr_i   = v[72:68];
        pc_next_i   = v[67:37];
        sum         = v[139:108] + v[107:76];
        #1;
        case (v[158:156])
            3'd1, 3'd4: begin
                kind = (v[158:156] == 3'd1) ? "alu" : "link";
                check_bit("forward_valid_o", 1'b1, forward_valid_o);
                check_word("fwd_value_o", exp_val, fwd_value_o);
                if (v[158:156] == 3'd4) begin
                    check_bit("branch_taken_o", v[0], branch_taken_o);
                end
                @(negedge clk_i);
                check_bit("wb_write_o", 1'b1, wb_write_o);
                check_word("wb_rd_value_o", exp_val, wb_rd_value_o);
                check_addr("wb_rd_addr_o", v[72:68], wb_rd_addr_o);
            end
            3'd3: begin
                kind = "branch";
                check_bit("branch_taken_o", v[0], branch_taken_o);
                check_pc("branch_target_o", sum[31:1], branch_target_o);
                @(negedge clk_i);
                check_bit("wb_write_o", 1'b0, wb_write_o);
            end
            3'd2: begin
                kind   = "div";
                cycles = 0;
                check_bit("forward_valid_o", 1'b0, forward_valid_o);
                while (!div_done_o && cycles < WAIT_LIMIT) begin
                    @(negedge clk_i);
                    cycles++;
                    if (!div_done_o) begin
                        check_bit("forward_valid_o", 1'b0, forward_valid_o);
                        check_bit("wb_write_o", 1'b0, wb_write_o);
                    end
                end
                if (!div_done_o) begin
                    $display("Timeout: divider never finished within %0d cycles", WAIT_LIMIT);
                    errors++;
                end else begin
                    if (cycles != DONE_DELAY) begin
                        $display("Divider done came after %0d cycles instead of %0d",
                                 cycles, DONE_DELAY);
                        errors++;
                    end
                    check_bit("forward_valid_o", 1'b1, forward_valid_o);
                    check_word("fwd_value_o", exp_val, fwd_value_o);
                    @(negedge clk_i);
                    check_bit("wb_write_o", 1'b1, wb_write_o);
                    check_word("wb_rd_value_o", exp_val, wb_rd_value_o);
                    check_addr("wb_rd_addr_o", v[72:68], wb_rd_addr_o);
                end
            end
            default: begin
                kind = "bubble";
                check_bit("branch_taken_o", v[0], branch_taken_o);
                @(negedge clk_i);
                check_bit("wb_write_o", 1'b0, wb_write_o);
            end
        endcase
        tests++;
        $display("test %0d %s %s", tests, kind, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        logic [159:0] v;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [3:0]   op;
        logic [4:0]   rd;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        unit_i      = exec_ops_pkg::UNIT_NONE;
        alu_op_i    = exec_ops_pkg::ALU_ADD;
        div_op_i    = exec_ops_pkg::DIV_DIV;
        branch_i    = exec_ops_pkg::BR_NONE;
        rd_addr_i   = '0;
        pc_next_i   = '0;
        operand_a_i = '0;
        operand_b_i = '0;
        cmp_flags_i = '0;
        errors      = 0;
        tests       = 0;
        lcg_state   = 32'h7452_c43d;
        for (int i = 0; i < MAX_VEC; i++) begin
            vectors[i] = '1; // Unit nibble f marks the end
        end
        $readmemh("bench/exec_testdata.txt", vectors);

        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        check_bit("wb_write_o", 1'b0, wb_write_o);
        check_bit("div_done_o", 1'b0, div_done_o);
        check_addr("wb_rd_addr_o", 5'd0, wb_rd_addr_o);
        check_word("wb_rd_value_o", 32'd0, wb_rd_value_o);

        for (int i = 0; i < MAX_VEC; i++) begin
            if (vectors[i][159:156] != 4'hf) begin
                run_vector(vectors[i]);
            end
        end

        for (int i = 0; i < 200; i++) begin
            op = 4'(lcg_next() % 32'd10);
            a  = lcg_next();
            b  = lcg_next();
            rd = 5'(lcg_next() >> 27);
            v  = {4'h1, op, 4'h0, 4'h0, 4'h0, a, b, {3'b0, rd}, 32'd0,
                  alu_expect(op, a, b), 4'h0};
            run_vector(v);
        end

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* bench/exec_testdata.txt */
// unit_aluop_divop_branch_flags(lt,ltu,eq)_opa_opb_rd_pcnext_expected_taken
// expected is the written value, zero for branches and bubbles
1_0_0_0_0_00000005_00000007_01_00000000_0000000c_0
1_1_0_0_0_00000005_00000007_02_00000000_fffffffe_0
1_2_0_0_0_f0f0f0f0_ff00ff00_03_00000000_f000f000_0
1_3_0_0_0_f0f0f0f0_ff00ff00_04_00000000_fff0fff0_0
1_4_0_0_0_f0f0f0f0_ff00ff00_05_00000000_0ff00ff0_0
1_5_0_0_0_00000001_0000001f_06_00000000_80000000_0
1_6_0_0_0_80000000_00000024_07_00000000_08000000_0
1_7_0_0_0_80000000_00000024_08_00000000_f8000000_0
1_8_0_0_0_ffffffff_00000001_09_00000000_00000001_0
1_9_0_0_0_ffffffff_00000001_0a_00000000_00000000_0
3_0_0_1_1_00001000_00000010_00_00000000_00000000_1
3_0_0_2_1_00001000_00000010_00_00000000_00000000_0
3_0_0_3_4_00001000_fffffff0_00_00000000_00000000_1
3_0_0_4_4_00001000_fffffff0_00_00000000_00000000_0
3_0_0_5_2_00001002_00000010_00_00000000_00000000_1
3_0_0_6_0_00001002_00000010_00_00000000_00000000_1
3_0_0_0_7_00001002_00000010_00_00000000_00000000_0
4_0_0_7_0_00002000_fffffff0_0b_00000104_00000104_1
4_0_0_8_0_00002001_00000004_0c_00000201_00000200_1
2_0_0_0_0_fffffff9_00000002_0d_00000000_fffffffd_0
2_0_2_0_0_fffffff9_00000002_0e_00000000_ffffffff_0
2_0_1_0_0_00000064_00000007_0f_00000000_0000000e_0
2_0_3_0_0_00000064_00000007_10_00000000_00000002_0
2_0_0_0_0_00000064_00000000_11_00000000_ffffffff_0
2_0_2_0_0_00000064_00000000_12_00000000_00000064_0
2_0_0_0_0_80000000_ffffffff_13_00000000_80000000_0
2_0_2_0_0_80000000_ffffffff_14_00000000_00000000_0
0_0_0_0_0_00000000_00000000_15_00000000_00000000_0

/* flist.f */
source/exec_types_pkg.sv
source/exec_ops_pkg.sv
source/exec_issue.sv
source/exec_alu.sv
source/exec_divider.sv
source/exec_writeback.sv
source/exec_stage.sv
bench/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module exec_stage_tb -o exec_sim &&
    ./obj_dir/exec_sim | tee /dev/stderr | grep -qx "No errors" &&
    echo "PASS" && exit 0 ||
    { echo "FAIL"; exit 1; }
